//--- filelist.f
softmax_pkg.sv
sweep_ctrl.sv
lane_reduce_tree.sv
lane_subtract.sv
softmax_front.sv
tb_clock_gen.sv
tb_softmax_front.sv

//--- lane_reduce_tree.sv
`timescale 1ns/1ps

module lane_reduce_tree #(
  parameter type                     in_t  = softmax_pkg::elem_t,
  parameter type                     acc_t = softmax_pkg::elem_t,
  parameter softmax_pkg::reduce_op_e OP    = softmax_pkg::REDUCE_MAX
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              clear,
  input  logic                              in_valid,
  input  in_t [softmax_pkg::NUM_LANES-1:0]  in_lanes,
  output acc_t                              result,
  output logic                              busy
);

  acc_t [softmax_pkg::NUM_LANES-1:0]   wide;
  acc_t [softmax_pkg::NUM_LANES/2-1:0] s1_q;
  acc_t [softmax_pkg::NUM_LANES/4-1:0] s2_q;
  acc_t                                s3_q;
  logic                                s1_v;
  logic                                s2_v;
  logic                                s3_v;
  acc_t                                identity;

  function automatic acc_t combine(acc_t a, acc_t b);
    if (OP == softmax_pkg::REDUCE_MAX) begin
      return (a > b) ? a : b;
    end
    return a + b;
  endfunction

  // sign extend each lane up to the accumulator width
  for (genvar i = 0; i < softmax_pkg::NUM_LANES; i++) begin : g_widen
    assign wide[i] = acc_t'(in_lanes[i]);
  end

  assign identity = (OP == softmax_pkg::REDUCE_MAX) ?
                    acc_t'(softmax_pkg::ELEM_MIN) : acc_t'(0);

  // pairwise levels, eight to four to two to one
  always_ff @(posedge clk) begin
    if (in_valid) begin
      for (int i = 0; i < softmax_pkg::NUM_LANES/2; i++) begin
        s1_q[i] <= combine(wide[2*i], wide[2*i+1]);
      end
    end
    if (s1_v) begin
      for (int i = 0; i < softmax_pkg::NUM_LANES/4; i++) begin
        s2_q[i] <= combine(s1_q[2*i], s1_q[2*i+1]);
      end
    end
    if (s2_v) begin
      s3_q <= combine(s2_q[0], s2_q[1]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_v <= 1'b0;
      s2_v <= 1'b0;
      s3_v <= 1'b0;
      result <= '0;
    end else begin
      s1_v <= in_valid;
      s2_v <= s1_v;
      s3_v <= s2_v;
      if (clear) begin
        result <= identity;
      end else if (s3_v) begin
        result <= combine(result, s3_q);
      end
    end
  end

  assign busy = s1_v | s2_v | s3_v;

  // a new run only starts once the previous one has fully drained
  a_clear_when_empty: assert property (@(posedge clk) disable iff (reset)
    clear |-> !in_valid && !busy);

endmodule

//--- lane_subtract.sv
`timescale 1ns/1ps

module lane_subtract (
  input  logic               clk,
  input  logic               reset,
  input  logic               in_valid,
  input  softmax_pkg::vec_t  in_vec,
  input  softmax_pkg::elem_t max_val,
  output logic               diff_valid,
  output softmax_pkg::vec_t  diff,
  output logic               busy
);

  logic [softmax_pkg::NUM_LANES-1:0][softmax_pkg::ELEM_W:0] full;
  softmax_pkg::vec_t                                        diff_next;

  // one extra bit holds the exact difference
  always_comb begin
    for (int i = 0; i < softmax_pkg::NUM_LANES; i++) begin
      full[i] = {in_vec[i][softmax_pkg::ELEM_W-1], in_vec[i]} -
                {max_val[softmax_pkg::ELEM_W-1], max_val};
      if (full[i][softmax_pkg::ELEM_W] && !full[i][softmax_pkg::ELEM_W-1]) begin
        diff_next[i] = softmax_pkg::ELEM_MIN;
      end else begin
        diff_next[i] = full[i][softmax_pkg::ELEM_W-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      diff <= diff_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      diff_valid <= 1'b0;
    end else begin
      diff_valid <= in_valid;
    end
  end

  assign busy = diff_valid;

  // max_val comes from the finished pass-1 tree, so nothing exceeds it
  for (genvar g = 0; g < softmax_pkg::NUM_LANES; g++) begin : g_chk
    a_diff_not_positive: assert property (@(posedge clk) disable iff (reset)
      diff_valid |-> diff[g] <= 0);
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the testbench, then decide on the log contents
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_softmax_front \
  -f filelist.f \
  && ./obj_dir/Vtb_softmax_front 2>&1 | tee sim.log
grep -q "No errors" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- softmax_front.sv
`timescale 1ns/1ps

module softmax_front (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  softmax_pkg::addr_t start_addr,
  input  softmax_pkg::addr_t end_addr,
  input  softmax_pkg::vec_t  rd_data,
  output logic               rd_en,
  output softmax_pkg::addr_t rd_addr,
  output logic               out_valid,
  output softmax_pkg::vec_t  out_data,
  output softmax_pkg::elem_t max_out,
  output softmax_pkg::sum_t  sum_out,
  output logic               done
);

  logic clear;
  logic max_in_valid;
  logic sub_in_valid;
  logic max_busy;
  logic sub_busy;
  logic sum_busy;

  sweep_ctrl ctrl (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .start_addr   (start_addr),
    .end_addr     (end_addr),
    .max_busy     (max_busy),
    .sub_busy     (sub_busy),
    .sum_busy     (sum_busy),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .clear        (clear),
    .max_in_valid (max_in_valid),
    .sub_in_valid (sub_in_valid),
    .done         (done)
  );

  // pass 1 reduces memory vectors to the running max
  lane_reduce_tree #(
    .in_t  (softmax_pkg::elem_t),
    .acc_t (softmax_pkg::elem_t),
    .OP    (softmax_pkg::REDUCE_MAX)
  ) max_tree (
    .clk      (clk),
    .reset    (reset),
    .clear    (clear),
    .in_valid (max_in_valid),
    .in_lanes (rd_data),
    .result   (max_out),
    .busy     (max_busy)
  );

  lane_subtract sub (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (sub_in_valid),
    .in_vec     (rd_data),
    .max_val    (max_out),
    .diff_valid (out_valid),
    .diff       (out_data),
    .busy       (sub_busy)
  );

  // the streamed differences also feed the sum
  lane_reduce_tree #(
    .in_t  (softmax_pkg::elem_t),
    .acc_t (softmax_pkg::sum_t),
    .OP    (softmax_pkg::REDUCE_SUM)
  ) sum_tree (
    .clk      (clk),
    .reset    (reset),
    .clear    (clear),
    .in_valid (out_valid),
    .in_lanes (out_data),
    .result   (sum_out),
    .busy     (sum_busy)
  );

endmodule

//--- softmax_pkg.sv
package softmax_pkg;

  localparam int ELEM_W = 16;
  localparam int NUM_LANES = 8;
  localparam int ADDR_W = 16;

  // longest run in vectors
  localparam int MAX_VECTORS = 256;

  // lane tree adds log2(lanes) bits, the running sum adds log2(count + 1)
  localparam int SUM_W = ELEM_W + $clog2(NUM_LANES) + $clog2(MAX_VECTORS + 1);

  typedef logic signed [ELEM_W-1:0] elem_t;

  // lane 0 sits in the low bits
  typedef elem_t [NUM_LANES-1:0] vec_t;

  typedef logic signed [SUM_W-1:0] sum_t;

  typedef logic [ADDR_W-1:0] addr_t;

  // identity for max, floor for the saturating subtract
  localparam elem_t ELEM_MIN = {1'b1, {(ELEM_W-1){1'b0}}};

  typedef enum logic {
    REDUCE_MAX,
    REDUCE_SUM
  } reduce_op_e;

endpackage

//--- sweep_ctrl.sv
`timescale 1ns/1ps

module sweep_ctrl (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  softmax_pkg::addr_t start_addr,
  input  softmax_pkg::addr_t end_addr,
  input  logic               max_busy,
  input  logic               sub_busy,
  input  logic               sum_busy,
  output logic               rd_en,
  output softmax_pkg::addr_t rd_addr,
  output logic               clear,
  output logic               max_in_valid,
  output logic               sub_in_valid,
  output logic               done
);

  typedef enum logic [2:0] {
    IDLE,
    PASS1,
    DRAIN1,
    PASS2,
    DRAIN2
  } state_e;

  state_e             state;
  softmax_pkg::addr_t lo_q;
  softmax_pkg::addr_t hi_q;
  logic               rd_en_q;
  logic               pass2_q;
  logic               last_addr;
  logic               drain1_done;
  logic               drain2_done;

  assign clear = (state == IDLE) && start;
  assign rd_en = (state == PASS1) || (state == PASS2);
  assign last_addr = (rd_addr == hi_q);

  // memory answers one cycle after rd_en
  assign max_in_valid = rd_en_q && !pass2_q;
  assign sub_in_valid = rd_en_q && pass2_q;

  // last vector must have left the subtractor and both trees
  assign drain1_done = !max_in_valid && !max_busy;
  assign drain2_done = !sub_in_valid && !sub_busy && !sum_busy;

  always_ff @(posedge clk) begin
    if (clear) begin
      lo_q <= start_addr;
      hi_q <= end_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      rd_addr <= '0;
      rd_en_q <= 1'b0;
      pass2_q <= 1'b0;
      done <= 1'b0;
    end else begin
      rd_en_q <= rd_en;
      pass2_q <= (state == PASS2);
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            rd_addr <= start_addr;
            state <= PASS1;
          end
        end
        PASS1: begin
          if (last_addr) begin
            state <= DRAIN1;
          end else begin
            rd_addr <= rd_addr + 1'b1;
          end
        end
        DRAIN1: begin
          // max is final here, sweep again from the first vector
          if (drain1_done) begin
            rd_addr <= lo_q;
            state <= PASS2;
          end
        end
        PASS2: begin
          if (last_addr) begin
            state <= DRAIN2;
          end else begin
            rd_addr <= rd_addr + 1'b1;
          end
        end
        DRAIN2: begin
          if (drain2_done) begin
            done <= 1'b1;
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  a_addr_in_range: assert property (@(posedge clk) disable iff (reset)
    rd_en |-> (rd_addr >= lo_q) && (rd_addr <= hi_q));

  a_done_pulse: assert property (@(posedge clk) disable iff (reset)
    done |=> !done);

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  localparam int HALF_PERIOD = 20;
  localparam int RESET_CYCLES = 8;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // release just after an edge, like the rest of the stimulus
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

//--- tb_softmax_front.sv
`timescale 1ns/1ps

module tb_softmax_front;

  localparam int DRIVE_DLY = 1;
  localparam int MEM_DEPTH = 256;
  // 40 + 1 + 12 + 20 + 25 vectors over all runs
  localparam int TOTAL_VECTORS = 98;
  localparam int TIMEOUT_CYCLES = 4 * TOTAL_VECTORS + 200;

  logic                      clk;
  logic                      reset;
  logic                      start;
  softmax_pkg::addr_t        start_addr;
  softmax_pkg::addr_t        end_addr;
  softmax_pkg::vec_t         rd_data;
  logic                      rd_en;
  softmax_pkg::addr_t        rd_addr;
  logic                      out_valid;
  softmax_pkg::vec_t         out_data;
  softmax_pkg::elem_t        max_out;
  softmax_pkg::sum_t         sum_out;
  logic                      done;

  softmax_pkg::vec_t         mem [0:MEM_DEPTH-1];
  softmax_pkg::addr_t        mem_addr_q;
  logic [31:0]               lfsr_state = 32'h4b46_1ae8;
  softmax_pkg::vec_t         exp_q[$];
  softmax_pkg::elem_t        exp_max;
  softmax_pkg::sum_t         exp_sum;
  int                        cycles = 0;
  int                        cyc = 0;
  int                        bursts = 0;
  int                        p2_cycle = 0;
  int                        runs_done = 0;
  int                        run_lo = 0;
  int                        run_hi = 0;
  int                        next_addr = 0;
  logic                      prev_rd_en = 1'b0;
  logic                      prev_out_valid = 1'b0;

  tb_clock_gen clk_gen (
    .clk   (clk),
    .reset (reset)
  );

  softmax_front DUT (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .start_addr (start_addr),
    .end_addr   (end_addr),
    .rd_data    (rd_data),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .max_out    (max_out),
    .sum_out    (sum_out),
    .done       (done)
  );

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic softmax_pkg::elem_t ref_max(int lo, int hi);
    int best;
    best = -32768;
    for (int a = lo; a <= hi; a++) begin
      for (int l = 0; l < softmax_pkg::NUM_LANES; l++) begin
        if (int'(mem[a][l]) > best) begin
          best = int'(mem[a][l]);
        end
      end
    end
    return softmax_pkg::elem_t'(best);
  endfunction

  // element minus max, clipped at the most negative element
  function automatic softmax_pkg::elem_t ref_diff(softmax_pkg::elem_t x, softmax_pkg::elem_t m);
    int d;
    d = int'(x) - int'(m);
    if (d < -32768) begin
      d = -32768;
    end
    return softmax_pkg::elem_t'(d);
  endfunction

  task automatic compare(input logic [127:0] got, input logic [127:0] expected, input string what);
    if (got !== expected) begin
      $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, expected);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic fill_memory();
    logic [15:0]        w;
    softmax_pkg::elem_t e;
    for (int a = 0; a < MEM_DEPTH; a++) begin
      for (int l = 0; l < softmax_pkg::NUM_LANES; l++) begin
        for (int b = 0; b < 16; b++) begin
          w[b] = lfsr_state[0];
          lfsr_state = lfsr_next(lfsr_state);
        end
        mem[a][l] = w;
      end
    end
    // second back to back range stays small so a stale max would show
    for (int a = 160; a <= 184; a++) begin
      for (int l = 0; l < softmax_pkg::NUM_LANES; l++) begin
        e = mem[a][l];
        mem[a][l] = e >>> 2;
      end
    end
    mem[103][2] = 16'h7fff;
    mem[108][5] = 16'h8000;
    mem[125][0] = 16'h7fff;
  endtask

  task automatic load_expected(input int lo, input int hi);
    softmax_pkg::elem_t m;
    softmax_pkg::vec_t  v;
    longint             total;
    m = ref_max(lo, hi);
    total = 0;
    exp_q.delete();
    for (int a = lo; a <= hi; a++) begin
      for (int l = 0; l < softmax_pkg::NUM_LANES; l++) begin
        v[l] = ref_diff(mem[a][l], m);
        total += longint'(v[l]);
      end
      exp_q.push_back(v);
    end
    exp_max = m;
    exp_sum = softmax_pkg::sum_t'(total);
  endtask

  // called a drive delay after an edge, returns the same way
  task automatic run_sweep(input int lo, input int hi, input bit poke_mid_run);
    load_expected(lo, hi);
    run_lo = lo;
    run_hi = hi;
    start = 1'b1;
    start_addr = softmax_pkg::addr_t'(lo);
    end_addr = softmax_pkg::addr_t'(hi);
    @(posedge clk);
    #DRIVE_DLY;
    start = 1'b0;
    if (poke_mid_run) begin
      repeat (6) @(posedge clk);
      #DRIVE_DLY;
      start = 1'b1;
      start_addr = 16'd200;
      end_addr = 16'd210;
      @(posedge clk);
      #DRIVE_DLY;
      start = 1'b0;
    end
    do @(posedge clk); while (!done);
    #DRIVE_DLY;
  endtask

  // memory answers the cycle after rd_en
  always @(posedge clk) begin
    if (rd_en) begin
      mem_addr_q = rd_addr;
      #DRIVE_DLY;
      rd_data = mem[mem_addr_q];
    end
  end

  always @(posedge clk) begin
    if (!reset) begin
      if (rd_en && !prev_rd_en) begin
        bursts++;
        next_addr = run_lo;
        if (bursts == 2) begin
          p2_cycle = cyc;
        end
      end
      // each pass reads start_addr to end_addr, one address per cycle
      if (rd_en) begin
        compare(rd_addr, next_addr, "rd_addr");
        next_addr++;
      end
      if (!rd_en && prev_rd_en) begin
        compare(next_addr, run_hi + 1, "address after the read burst");
      end
      if (out_valid && !prev_out_valid) begin
        compare(cyc - p2_cycle, 2, "cycles from pass-2 rd_en to out_valid");
      end
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          $display("out_valid at %0t ns with no vector left to expect", $time);
          $display("Errors found");
          $fatal(1);
        end else begin
          compare(out_data, exp_q.pop_front(), "out_data");
        end
      end
      if (done) begin
        compare(max_out, exp_max, "max_out at done");
        compare(sum_out, exp_sum, "sum_out at done");
        compare(exp_q.size(), 0, "vectors still expected at done");
        bursts = 0;
        runs_done++;
      end
      prev_rd_en = rd_en;
      prev_out_valid = out_valid;
      cyc++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the runs never finished", TIMEOUT_CYCLES);
      $display("Errors found");
      $fatal(1);
    end
  end

  initial begin
    start = 1'b0;
    start_addr = '0;
    end_addr = '0;
    rd_data = '0;
    fill_memory();
    wait (!reset);
    repeat (20) begin
      @(posedge clk);
      compare(rd_en, 1'b0, "rd_en while idle");
      compare(out_valid, 1'b0, "out_valid while idle");
      compare(done, 1'b0, "done while idle");
      compare(max_out, 0, "max_out after reset");
      compare(sum_out, 0, "sum_out after reset");
    end
    #DRIVE_DLY;
    run_sweep(0, 39, 1'b0);
    run_sweep(50, 50, 1'b0);
    run_sweep(100, 111, 1'b0);
    run_sweep(120, 139, 1'b1);
    run_sweep(160, 184, 1'b0);
    repeat (10) begin
      @(posedge clk);
      compare(rd_en, 1'b0, "rd_en after the last run");
    end
    compare(runs_done, 5, "number of completed runs");
    $display("No errors");
    $finish;
  end

endmodule
